// File: all.f
verilog/slapfight_pkg.sv
verilog/video_timing.sv
verilog/scroll_regs.sv
verilog/write_arbiter.sv
verilog/layer_mixer.sv
verilog/palette_ram.sv
verilog/slapfight_video.sv
bench/clock_gen.sv
bench/tb_slapfight_video.sv

// File: bench/tb_slapfight_video.sv
`default_nettype none

module tb_slapfight_video;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int H_TOTAL      = 64;
	localparam int H_ACTIVE     = 48;
	localparam int H_SYNC_START = 52;
	localparam int H_SYNC_LEN   = 6;
	localparam int V_TOTAL      = 40;
	localparam int V_ACTIVE     = 32;
	localparam int V_SYNC_START = 34;
	localparam int V_SYNC_LEN   = 2;
	localparam int FRAME        = H_TOTAL * V_TOTAL;
	localparam int CYCLE_LIMIT  = 6 * FRAME + 2000;
	localparam int SETTLE       = 4;  // Quiet cycles until a write reaches every output

	logic                      pixel_clk;
	logic                      RESET_n;
	slapfight_pkg::bus_wr_t    cpu_wr;
	slapfight_pkg::bus_wr_t    dl_wr;
	logic                      cpu_wr_valid;
	logic                      cpu_wr_ready;
	logic                      dl_wr_valid;
	logic                      dl_wr_ready;
	slapfight_pkg::layer_pix_t layer_pix;
	slapfight_pkg::coord_t     pix_coord;
	slapfight_pkg::coord_t     scroll_coord;
	slapfight_pkg::rgb_t       disp_rgb;
	slapfight_pkg::sync_t      disp_sync;

	// Reference model state
	integer                 seed = 32'h1a3b;
	int                     errors = 0;
	int                     cycle_count = 0;
	int                     quiet = 0;
	int                     h_m = 0;     // Pixel count of the current pix_coord
	int                     line_m = 0;  // Line count of the current pix_coord
	logic [11:0]            pal_model [256];
	logic                   pal_known [256];
	logic [8:0]             hscroll_m = '0;
	logic [7:0]             vscroll_m = '0;
	logic                   flip_m = 1'b0;
	logic                   last_cpu_won = 1'b1;  // Download port wins the first contention
	slapfight_pkg::bus_wr_t cpu_q [$];
	slapfight_pkg::bus_wr_t dl_q [$];
	logic                   cpu_taken = 1'b0;
	logic                   dl_taken = 1'b0;
	logic                   bus_exp_en = 1'b0;
	slapfight_pkg::bus_wr_t bus_exp;
	slapfight_pkg::coord_t  prev_pix;
	logic [11:0]            pipe_rgb [2];
	slapfight_pkg::sync_t   pipe_sync [2];
	logic                   pipe_rgb_ok [2] = '{default: 1'b0};
	logic                   pipe_sync_ok [2] = '{default: 1'b0};
	logic                   was_on [4] = '{default: 1'b1};
	logic                   armed [4] = '{default: 1'b0};
	int                     run_len [4] = '{default: 0};
	int                     last_rise [4] = '{default: 0};

	clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(16)) u_clock (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n)
	);

	slapfight_video #(
		.H_TOTAL      (H_TOTAL),
		.H_ACTIVE     (H_ACTIVE),
		.H_SYNC_START (H_SYNC_START),
		.H_SYNC_LEN   (H_SYNC_LEN),
		.V_TOTAL      (V_TOTAL),
		.V_ACTIVE     (V_ACTIVE),
		.V_SYNC_START (V_SYNC_START),
		.V_SYNC_LEN   (V_SYNC_LEN)
	) uut (
		.pixel_clk      (pixel_clk),
		.RESET_n        (RESET_n),
		.cpu_wr_i       (cpu_wr),
		.cpu_wr_valid_i (cpu_wr_valid),
		.cpu_wr_ready_o (cpu_wr_ready),
		.dl_wr_i        (dl_wr),
		.dl_wr_valid_i  (dl_wr_valid),
		.dl_wr_ready_o  (dl_wr_ready),
		.layer_pix_i    (layer_pix),
		.pix_coord_o    (pix_coord),
		.scroll_coord_o (scroll_coord),
		.rgb_o          (disp_rgb),
		.sync_o         (disp_sync)
	);

	// =========================================================================
	// Checks and expected values
	// =========================================================================
	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %0h, actual %0h (cycle %0d)",
				name, expected, actual, cycle_count);
		end
	endtask

	// Run length of an active level, and the distance between its starts
	task automatic track_run(input int idx, input logic on, input int exp_len,
		input int exp_period, input string name);
		if (on && !was_on[idx]) begin
			if (armed[idx]) begin
				check_value({name, " period"}, exp_period, cycle_count - last_rise[idx]);
			end
			armed[idx]     = 1'b1;
			last_rise[idx] = cycle_count;
			run_len[idx]   = 0;
		end
		if (on) begin
			run_len[idx]++;
		end else if (was_on[idx] && armed[idx]) begin
			check_value({name, " length"}, exp_len, run_len[idx]);
		end
		was_on[idx] = on;
	endtask

	function automatic logic [7:0] pick_code(slapfight_pkg::layer_pix_t lp);
		if (lp.fg[slapfight_pkg::FG_OPAQUE_BITS-1:0] != '0) begin
			return lp.fg;
		end else if (lp.sp[slapfight_pkg::SP_OPAQUE_BITS-1:0] != '0) begin
			return lp.sp;
		end
		return lp.bg;
	endfunction

	// Sync and blank from the raw counts
	function automatic slapfight_pkg::sync_t sync_at(int h, int line);
		slapfight_pkg::sync_t s;
		s.hsync  = !(h >= H_SYNC_START && h < H_SYNC_START + H_SYNC_LEN);
		s.vsync  = !(line >= V_SYNC_START && line < V_SYNC_START + V_SYNC_LEN);
		s.hblank = (h >= H_ACTIVE);
		s.vblank = (line >= V_ACTIVE);
		return s;
	endfunction

	function automatic slapfight_pkg::coord_t pos_at(int h, int line, logic flipped);
		slapfight_pkg::coord_t p;
		p.h = flipped ? 9'(H_TOTAL - 1 - h) : 9'(h);  // Flipped h counts down
		p.v = flipped ? 8'(255 - line) : 8'(line);
		return p;
	endfunction

	task automatic apply_write(input slapfight_pkg::bus_wr_t w);
		if (w.addr <= 9'h0FF) begin
			pal_model[w.addr[7:0]] = w.data;
			pal_known[w.addr[7:0]] = 1'b1;
		end else if (w.addr == slapfight_pkg::REG_HSCROLL_LO) begin
			hscroll_m[7:0] = w.data[7:0];
		end else if (w.addr == slapfight_pkg::REG_HSCROLL_HI) begin
			hscroll_m[8] = w.data[0];
		end else if (w.addr == slapfight_pkg::REG_VSCROLL) begin
			vscroll_m = w.data[7:0];
		end else if (w.addr == slapfight_pkg::REG_FLIP) begin
			flip_m = w.data[0];
		end
		quiet = 0;
	endtask

	// Sampled just before the rising edge, where the grant is settled
	task automatic sample_handshake();
		logic exp_cpu;
		logic exp_dl;
		if (cpu_wr_valid && dl_wr_valid) begin
			exp_dl  = last_cpu_won;  // Alternate under contention
			exp_cpu = !last_cpu_won;
		end else begin
			exp_dl  = dl_wr_valid;
			exp_cpu = cpu_wr_valid;
		end
		check_value("ready exclusive", 1'b0, cpu_wr_ready && dl_wr_ready);
		check_value("cpu ready", exp_cpu, cpu_wr_ready);
		check_value("dl ready", exp_dl, dl_wr_ready);
		cpu_taken  = cpu_wr_valid && cpu_wr_ready;
		dl_taken   = dl_wr_valid && dl_wr_ready;
		bus_exp_en = cpu_taken || dl_taken;
		if (cpu_taken) begin
			bus_exp      = cpu_wr;
			last_cpu_won = 1'b1;
			apply_write(cpu_wr);
			cpu_q.delete(0);
		end
		if (dl_taken) begin
			bus_exp      = dl_wr;
			last_cpu_won = 1'b0;
			apply_write(dl_wr);
			dl_q.delete(0);
		end
	endtask

	// =========================================================================
	// One pixel clock
	// =========================================================================
	task automatic step_cycle();
		slapfight_pkg::layer_pix_t lp;
		logic [7:0]                code;
		@(negedge pixel_clk);
		quiet++;
		check_value("bus_wr_en", bus_exp_en, uut.bus_wr_en);  // One pulse per accepted write
		if (bus_exp_en) begin
			check_value("bus_wr", bus_exp, uut.bus_wr);
		end
		track_run(0, disp_sync.hblank, H_TOTAL - H_ACTIVE, H_TOTAL, "hblank");
		track_run(1, !disp_sync.hsync, H_SYNC_LEN, H_TOTAL, "hsync");
		track_run(2, disp_sync.vblank, (V_TOTAL - V_ACTIVE) * H_TOTAL, FRAME, "vblank");
		track_run(3, !disp_sync.vsync, V_SYNC_LEN * H_TOTAL, FRAME, "vsync");
		if (pipe_rgb_ok[1]) begin
			check_value("rgb", pipe_rgb[1], disp_rgb);
		end
		if (pipe_sync_ok[1]) begin
			check_value("sync", pipe_sync[1], disp_sync);
		end
		if (quiet >= SETTLE) begin
			check_value("position", pos_at(h_m, line_m, flip_m), pix_coord);
			check_value("scroll h", 9'(prev_pix.h + hscroll_m), scroll_coord.h);
			check_value("scroll v", 8'(prev_pix.v + vscroll_m), scroll_coord.v);
		end
		prev_pix = pix_coord;

		// Often transparent, so all three layers get shown
		lp = 24'($random(seed));
		if (($random(seed) & 1) == 0) begin
			lp.fg[slapfight_pkg::FG_OPAQUE_BITS-1:0] = '0;
		end
		if (($random(seed) & 1) == 0) begin
			lp.sp[slapfight_pkg::SP_OPAQUE_BITS-1:0] = '0;
		end
		code            = pick_code(lp);
		pipe_rgb[1]     = pipe_rgb[0];
		pipe_rgb_ok[1]  = pipe_rgb_ok[0];
		pipe_sync[1]    = pipe_sync[0];
		pipe_sync_ok[1] = pipe_sync_ok[0];
		pipe_rgb[0]     = pal_model[code];
		pipe_rgb_ok[0]  = (quiet >= SETTLE) && pal_known[code];
		pipe_sync[0]    = sync_at(h_m, line_m);
		pipe_sync_ok[0] = 1'b1;
		layer_pix       = lp;

		// Counts of the next pixel
		if (h_m == H_TOTAL - 1) begin
			h_m    = 0;
			line_m = (line_m == V_TOTAL - 1) ? 0 : line_m + 1;
		end else begin
			h_m++;
		end

		// A request stays put until it is taken
		if (!cpu_wr_valid || cpu_taken) begin
			cpu_wr_valid = (cpu_q.size() > 0) && (($random(seed) & 1) != 0);
			if (cpu_wr_valid) begin
				cpu_wr = cpu_q[0];
			end
		end
		if (!dl_wr_valid || dl_taken) begin
			dl_wr_valid = (dl_q.size() > 0) && (($random(seed) & 3) != 0);
			if (dl_wr_valid) begin
				dl_wr = dl_q[0];
			end
		end
		#1;
		sample_handshake();
	endtask

	task automatic run_cycles(input int n);
		repeat (n) step_cycle();
	endtask

	task automatic drain_writes();
		while (cpu_q.size() > 0 || dl_q.size() > 0 || cpu_wr_valid || dl_wr_valid) begin
			step_cycle();
		end
	endtask

	task automatic queue_cpu(input logic [8:0] addr, input logic [11:0] data);
		slapfight_pkg::bus_wr_t w;
		w.addr = addr;
		w.data = data;
		cpu_q.push_back(w);
	endtask

	// =========================================================================
	// Test sequence
	// =========================================================================
	initial begin
		slapfight_pkg::bus_wr_t w;
		cpu_wr       = '0;
		dl_wr        = '0;
		cpu_wr_valid = 1'b0;
		dl_wr_valid  = 1'b0;
		layer_pix    = '0;
		for (int i = 0; i < 256; i++) begin
			pal_known[i] = 1'b0;
			w.addr       = 9'(i);
			w.data       = 12'($random(seed));
			dl_q.push_back(w);  // Download fills the whole palette
		end
		for (int i = 0; i < 48; i++) begin
			case ($unsigned($random(seed)) % 4)
				0: w.addr = slapfight_pkg::REG_HSCROLL_LO;
				1: w.addr = slapfight_pkg::REG_HSCROLL_HI;
				2: w.addr = slapfight_pkg::REG_VSCROLL;
				default: w.addr = 9'($random(seed) & 255);
			endcase
			queue_cpu(w.addr, 12'($random(seed)));
		end
		@(posedge RESET_n);
		drain_writes();
		run_cycles(FRAME);
		queue_cpu(slapfight_pkg::REG_HSCROLL_LO, 12'($random(seed)));
		queue_cpu(slapfight_pkg::REG_HSCROLL_HI, 12'($random(seed)));
		queue_cpu(slapfight_pkg::REG_VSCROLL, 12'($random(seed)));
		queue_cpu(slapfight_pkg::REG_FLIP, 12'h001);
		drain_writes();
		run_cycles(FRAME + 200);  // Flipped frame
		queue_cpu(slapfight_pkg::REG_FLIP, 12'h000);
		drain_writes();
		run_cycles(300);
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	always @(posedge pixel_clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors: %0d", errors);
			$display("Something failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
`default_nettype none

module clock_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 16
) (
	output logic pixel_clk,
	output logic RESET_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		pixel_clk = 1'b0;
		forever #(PERIOD_NS / 2.0) pixel_clk = ~pixel_clk;
	end

	// Released on a falling edge, away from the DUT's active edge
	initial begin
		RESET_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge pixel_clk);
		@(negedge pixel_clk);
		RESET_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: verilog/slapfight_video.sv
`default_nettype none

module slapfight_video #(
	parameter int H_TOTAL      = 384,
	parameter int H_ACTIVE     = 256,
	parameter int H_SYNC_START = 288,
	parameter int H_SYNC_LEN   = 32,
	parameter int V_TOTAL      = 264,
	parameter int V_ACTIVE     = 240,
	parameter int V_SYNC_START = 244,
	parameter int V_SYNC_LEN   = 4
) (
	input  wire logic                       pixel_clk,
	input  wire logic                       RESET_n,
	// Writers
	input  wire slapfight_pkg::bus_wr_t     cpu_wr_i,
	input  wire logic                       cpu_wr_valid_i,
	output logic                            cpu_wr_ready_o,
	input  wire slapfight_pkg::bus_wr_t     dl_wr_i,
	input  wire logic                       dl_wr_valid_i,
	output logic                            dl_wr_ready_o,
	// Renderers
	input  wire slapfight_pkg::layer_pix_t  layer_pix_i,
	output slapfight_pkg::coord_t           pix_coord_o,
	output slapfight_pkg::coord_t           scroll_coord_o,
	// Display
	output slapfight_pkg::rgb_t             rgb_o,
	output slapfight_pkg::sync_t            sync_o
);

	slapfight_pkg::bus_wr_t             bus_wr;
	logic                               bus_wr_en;
	logic                               flip;
	slapfight_pkg::sync_t               timing_sync;
	slapfight_pkg::sync_t               mix_sync;
	logic [slapfight_pkg::COLOUR_W-1:0] colour_idx;

	write_arbiter u_arbiter (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.cpu_wr_i    (cpu_wr_i),
		.cpu_valid_i (cpu_wr_valid_i),
		.cpu_ready_o (cpu_wr_ready_o),
		.dl_wr_i     (dl_wr_i),
		.dl_valid_i  (dl_wr_valid_i),
		.dl_ready_o  (dl_wr_ready_o),
		.bus_wr_o    (bus_wr),
		.bus_wr_en_o (bus_wr_en)
	);

	video_timing #(
		.H_TOTAL      (H_TOTAL),
		.H_ACTIVE     (H_ACTIVE),
		.H_SYNC_START (H_SYNC_START),
		.H_SYNC_LEN   (H_SYNC_LEN),
		.V_TOTAL      (V_TOTAL),
		.V_ACTIVE     (V_ACTIVE),
		.V_SYNC_START (V_SYNC_START),
		.V_SYNC_LEN   (V_SYNC_LEN)
	) u_timing (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.flip_i      (flip),
		.pix_coord_o (pix_coord_o),
		.sync_o      (timing_sync)
	);

	scroll_regs u_scroll (
		.pixel_clk      (pixel_clk),
		.RESET_n        (RESET_n),
		.bus_wr_i       (bus_wr),
		.bus_wr_en_i    (bus_wr_en),
		.pix_coord_i    (pix_coord_o),
		.flip_o         (flip),
		.scroll_coord_o (scroll_coord_o)
	);

	// Two stages from pixel position to colour out
	layer_mixer u_mixer (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.layer_pix_i  (layer_pix_i),
		.sync_i       (timing_sync),
		.colour_idx_o (colour_idx),
		.sync_o       (mix_sync)
	);

	palette_ram u_palette (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.bus_wr_i     (bus_wr),
		.bus_wr_en_i  (bus_wr_en),
		.colour_idx_i (colour_idx),
		.sync_i       (mix_sync),
		.rgb_o        (rgb_o),
		.sync_o       (sync_o)
	);

endmodule

`default_nettype wire

// File: verilog/palette_ram.sv
`default_nettype none

module palette_ram (
	input  wire logic                         pixel_clk,
	input  wire logic                         RESET_n,
	input  wire slapfight_pkg::bus_wr_t       bus_wr_i,
	input  wire logic                         bus_wr_en_i,
	input  wire logic [slapfight_pkg::COLOUR_W-1:0] colour_idx_i,
	input  wire slapfight_pkg::sync_t         sync_i,
	output slapfight_pkg::rgb_t               rgb_o,
	output slapfight_pkg::sync_t              sync_o
);

	localparam int CW          = slapfight_pkg::COLOUR_W;
	localparam int AW          = slapfight_pkg::ADDR_W;
	localparam int PAL_ENTRIES = 2 ** CW;

	slapfight_pkg::rgb_t pal_mem [PAL_ENTRIES];
	logic                pal_we;

	// Upper address bits pick the palette window
	assign pal_we = bus_wr_en_i &&
		(bus_wr_i.addr[AW-1:CW] == slapfight_pkg::PAL_BASE[AW-1:CW]);

	// =========================================================================
	// Colour memory
	// =========================================================================
	always_ff @(posedge pixel_clk) begin
		if (pal_we) begin
			pal_mem[bus_wr_i.addr[CW-1:0]] <= slapfight_pkg::rgb_t'(bus_wr_i.data);
		end
	end

	// Same-edge write shows up on the following read
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			rgb_o  <= '0;
			sync_o <= slapfight_pkg::SYNC_IDLE;
		end else begin
			rgb_o  <= pal_mem[colour_idx_i];
			sync_o <= sync_i;  // Matches the lookup stage
		end
	end

endmodule

`default_nettype wire

// File: verilog/layer_mixer.sv
`default_nettype none

module layer_mixer (
	input  wire logic                       pixel_clk,
	input  wire logic                       RESET_n,
	input  wire slapfight_pkg::layer_pix_t  layer_pix_i,
	input  wire slapfight_pkg::sync_t       sync_i,
	output logic [slapfight_pkg::COLOUR_W-1:0] colour_idx_o,
	output slapfight_pkg::sync_t            sync_o
);

	logic [slapfight_pkg::COLOUR_W-1:0] colour_sel;

	// Foreground over sprites over background
	always_comb begin
		if (|layer_pix_i.fg[slapfight_pkg::FG_OPAQUE_BITS-1:0]) begin
			colour_sel = layer_pix_i.fg;
		end else if (|layer_pix_i.sp[slapfight_pkg::SP_OPAQUE_BITS-1:0]) begin
			colour_sel = layer_pix_i.sp;
		end else begin
			colour_sel = layer_pix_i.bg;  // Background is always opaque
		end
	end

	always_ff @(posedge pixel_clk) begin
		colour_idx_o <= colour_sel;
	end

	// Sync rides along with the pixel
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			sync_o <= slapfight_pkg::SYNC_IDLE;
		end else begin
			sync_o <= sync_i;
		end
	end

endmodule

`default_nettype wire

// File: verilog/write_arbiter.sv
`default_nettype none

module write_arbiter (
	input  wire logic                    pixel_clk,
	input  wire logic                    RESET_n,
	input  wire slapfight_pkg::bus_wr_t  cpu_wr_i,
	input  wire logic                    cpu_valid_i,
	output logic                         cpu_ready_o,
	input  wire slapfight_pkg::bus_wr_t  dl_wr_i,
	input  wire logic                    dl_valid_i,
	output logic                         dl_ready_o,
	output slapfight_pkg::bus_wr_t       bus_wr_o,
	output logic                         bus_wr_en_o
);

	logic grant_cpu;
	logic grant_dl;
	logic last_dl;  // Last accepted write came from the download port

	// =========================================================================
	// Round-robin grant
	// =========================================================================
	always_comb begin
		if (cpu_valid_i && dl_valid_i) begin
			grant_dl  = !last_dl;  // Contention goes to whoever waited
			grant_cpu = last_dl;
		end else begin
			grant_dl  = dl_valid_i;
			grant_cpu = cpu_valid_i;
		end
	end

	assign cpu_ready_o = grant_cpu;
	assign dl_ready_o  = grant_dl;

	// Cleared state lets the download port win the first contention
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			last_dl     <= 1'b0;
			bus_wr_en_o <= 1'b0;
		end else begin
			bus_wr_en_o <= grant_cpu || grant_dl;  // One pulse per accepted write
			if (grant_cpu || grant_dl) begin
				last_dl <= grant_dl;
			end
		end
	end

	// Winner's request onto the bus
	always_ff @(posedge pixel_clk) begin
		if (grant_dl) begin
			bus_wr_o <= dl_wr_i;
		end else if (grant_cpu) begin
			bus_wr_o <= cpu_wr_i;
		end
	end

	// =========================================================================
	// Checks
	// =========================================================================
	assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		!(cpu_ready_o && dl_ready_o));

	assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		($rose(cpu_ready_o) |-> cpu_valid_i) and ($rose(dl_ready_o) |-> dl_valid_i));

	// A writer that lost the contention is served on the next cycle
	assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(dl_ready_o && cpu_valid_i) |=> cpu_ready_o);

endmodule

`default_nettype wire

// File: verilog/scroll_regs.sv
`default_nettype none

module scroll_regs (
	input  wire logic                    pixel_clk,
	input  wire logic                    RESET_n,
	input  wire slapfight_pkg::bus_wr_t  bus_wr_i,
	input  wire logic                    bus_wr_en_i,
	input  wire slapfight_pkg::coord_t   pix_coord_i,
	output logic                         flip_o,
	output slapfight_pkg::coord_t        scroll_coord_o
);

	logic [slapfight_pkg::H_W-1:0] hscroll;
	logic [slapfight_pkg::V_W-1:0] vscroll;

	// =========================================================================
	// Register writes from the shared bus
	// =========================================================================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hscroll <= '0;
			vscroll <= '0;
			flip_o  <= 1'b0;
		end else if (bus_wr_en_i) begin
			case (bus_wr_i.addr)
				slapfight_pkg::REG_HSCROLL_LO: begin
					hscroll[7:0] <= bus_wr_i.data[7:0];
				end
				slapfight_pkg::REG_HSCROLL_HI: begin
					hscroll[8] <= bus_wr_i.data[0];
				end
				slapfight_pkg::REG_VSCROLL: begin
					vscroll <= bus_wr_i.data[7:0];
				end
				slapfight_pkg::REG_FLIP: begin
					flip_o <= bus_wr_i.data[0];
				end
				default: begin
					// Palette and unused addresses
				end
			endcase
		end
	end

	// =========================================================================
	// Scroll adders
	// =========================================================================
	// Both sums wrap at their own width, 512 across and 256 down
	always_ff @(posedge pixel_clk) begin
		scroll_coord_o.h <= pix_coord_i.h + hscroll;
		scroll_coord_o.v <= pix_coord_i.v + vscroll;
	end

endmodule

`default_nettype wire

// File: verilog/video_timing.sv
`default_nettype none

module video_timing #(
	parameter int H_TOTAL      = 384,
	parameter int H_ACTIVE     = 256,
	parameter int H_SYNC_START = 288,
	parameter int H_SYNC_LEN   = 32,
	parameter int V_TOTAL      = 264,
	parameter int V_ACTIVE     = 240,
	parameter int V_SYNC_START = 244,
	parameter int V_SYNC_LEN   = 4
) (
	input  wire logic                  pixel_clk,
	input  wire logic                  RESET_n,
	input  wire logic                  flip_i,
	output slapfight_pkg::coord_t      pix_coord_o,
	output slapfight_pkg::sync_t       sync_o
);

	localparam int HC_W = slapfight_pkg::H_W;
	localparam int VC_W = slapfight_pkg::V_W + 1;  // Line count goes past 255

	localparam logic [HC_W-1:0] H_LAST = HC_W'(H_TOTAL - 1);
	localparam logic [HC_W-1:0] H_ACT  = HC_W'(H_ACTIVE);
	localparam logic [HC_W-1:0] HS_BEG = HC_W'(H_SYNC_START);
	localparam logic [HC_W-1:0] HS_END = HC_W'(H_SYNC_START + H_SYNC_LEN);
	localparam logic [VC_W-1:0] V_LAST = VC_W'(V_TOTAL - 1);
	localparam logic [VC_W-1:0] V_ACT  = VC_W'(V_ACTIVE);
	localparam logic [VC_W-1:0] VS_BEG = VC_W'(V_SYNC_START);
	localparam logic [VC_W-1:0] VS_END = VC_W'(V_SYNC_START + V_SYNC_LEN);

	logic [HC_W-1:0]       h_cnt;
	logic [VC_W-1:0]       v_cnt;
	slapfight_pkg::coord_t pos_next;
	slapfight_pkg::sync_t  sync_next;

	// =========================================================================
	// Pixel and line counters
	// =========================================================================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;  // Next line or next frame
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Flip mirrors the position only, sync and blank follow the raw counts
	always_comb begin
		if (flip_i) begin
			pos_next.h = H_LAST - h_cnt;
			pos_next.v = 8'd255 - v_cnt[slapfight_pkg::V_W-1:0];
		end else begin
			pos_next.h = h_cnt;
			pos_next.v = v_cnt[slapfight_pkg::V_W-1:0];
		end
		sync_next.hsync  = !(h_cnt >= HS_BEG && h_cnt < HS_END);
		sync_next.vsync  = !(v_cnt >= VS_BEG && v_cnt < VS_END);
		sync_next.hblank = (h_cnt >= H_ACT);
		sync_next.vblank = (v_cnt >= V_ACT);
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			pix_coord_o <= '0;
			sync_o      <= slapfight_pkg::SYNC_IDLE;
		end else begin
			pix_coord_o <= pos_next;
			sync_o      <= sync_next;
		end
	end

	// Mirrored or not, the pixel stays inside the line
	assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		pix_coord_o.h < H_TOTAL);

endmodule

`default_nettype wire

// File: verilog/slapfight_pkg.sv
`default_nettype none

package slapfight_pkg;

	// =========================================================================
	// Widths
	// =========================================================================
	localparam int H_W      = 9;   // Horizontal pixel position
	localparam int V_W      = 8;   // Vertical line position
	localparam int ADDR_W   = 9;   // Shared write bus address
	localparam int DATA_W   = 12;  // Shared write bus data
	localparam int COLOUR_W = 8;   // Colour index, also the palette address
	localparam int CHAN_W   = 4;   // One colour channel

	// =========================================================================
	// Write bus address map
	// =========================================================================
	// Palette spans 0x000 to 0x0FF, data holds red 11:8, green 7:4, blue 3:0
	localparam logic [ADDR_W-1:0] PAL_BASE       = 9'h000;
	localparam logic [ADDR_W-1:0] REG_HSCROLL_LO = 9'h100;  // Data 7:0
	localparam logic [ADDR_W-1:0] REG_HSCROLL_HI = 9'h101;  // Data 0 is scroll bit 8
	localparam logic [ADDR_W-1:0] REG_VSCROLL    = 9'h102;  // Data 7:0
	localparam logic [ADDR_W-1:0] REG_FLIP       = 9'h103;  // Data 0

	// Low code bits that mark a layer pixel as opaque
	localparam int FG_OPAQUE_BITS = 2;
	localparam int SP_OPAQUE_BITS = 4;

	// =========================================================================
	// Shared structs
	// =========================================================================
	typedef struct packed {
		logic [H_W-1:0] h;
		logic [V_W-1:0] v;
	} coord_t;

	typedef struct packed {
		logic hsync;   // Active low
		logic vsync;   // Active low
		logic hblank;
		logic vblank;
	} sync_t;

	typedef struct packed {
		logic [COLOUR_W-1:0] fg;
		logic [COLOUR_W-1:0] sp;
		logic [COLOUR_W-1:0] bg;
	} layer_pix_t;

	typedef struct packed {
		logic [CHAN_W-1:0] r;
		logic [CHAN_W-1:0] g;
		logic [CHAN_W-1:0] b;
	} rgb_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} bus_wr_t;

	// Sync released, both blanks active
	localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, hblank: 1'b1, vblank: 1'b1};

endpackage

`default_nettype wire
